// ==== compile.f ====
hdl/gemm_sched_pkg.sv
hdl/bank_fifo.sv
hdl/wb_bank_writer.sv
hdl/psum_scanner.sv
hdl/weight_input_scanner.sv
hdl/gemm_sched_top.sv
testbench/tb_gemm_sched.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the GEMM scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

{ verilator --binary --timing --assert --top-module tb_gemm_sched -f compile.f \
    && ./obj_dir/Vtb_gemm_sched; } > sim.log 2>&1 || echo "TESTS FAILED" >> sim.log

cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

// ==== testbench/tb_gemm_sched.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_gemm_sched;
    import gemm_sched_pkg::*;

    localparam int DEPTH   = 8;
    localparam int TIMEOUT = 200;  // cycles allowed for any single wait

    logic       CLK;
    logic       nRST;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [3:0] wb_adr;
    row_data_t  wb_dat;
    logic       wb_ack;
    logic       new_weight;
    logic       drained;
    logic       weight_en;
    logic       input_en;
    row_sel_t   wi_row;
    row_data_t  wi_data;
    logic       ps_en;
    row_sel_t   ps_row;
    row_data_t  ps_data;

    string       test_name;
    logic [31:0] lfsr;
    row_data_t   grp_rows [ROWS_PER_GROUP];      // group made by the last queue_group
    row_data_t   exp_rows [NUM_BANKS][$];        // rows still owed, per bank
    tag_t        exp_kind [NUM_BANKS][$];        // one entry per owed group
    tag_t        delivered [$];                  // group kinds in arrival order
    row_data_t   got_rows [4][ROWS_PER_GROUP];   // indexed by tag
    int          next_row [4];
    int          overlap_count;                  // cycles with input_en and ps_en both high

    gemm_sched_top #(
        .DEPTH (DEPTH)
    ) dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat     (wb_dat),
        .wb_ack     (wb_ack),
        .new_weight (new_weight),
        .drained    (drained),
        .weight_en  (weight_en),
        .input_en   (input_en),
        .wi_row     (wi_row),
        .wi_data    (wi_data),
        .ps_en      (ps_en),
        .ps_row     (ps_row),
        .ps_data    (ps_data)
    );

    always #50 CLK = ~CLK;

    // ******************************
    // checking and stimulus helpers
    // ******************************
    task automatic check_eq(input string what, input logic [63:0] expected,
                            input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: %s expected %0h actual %0h", test_name, what, expected, actual);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail_now(input string why);
        $display("[ERROR] %s: %s", test_name, why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_row(output row_data_t v);
        for (int i = 0; i < DATA_W; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];  // one step per bit
        end
    endtask

    task automatic queue_group(input bank_idx_t bank, input tag_t kind);
        for (int r = 0; r < ROWS_PER_GROUP; r++) begin
            random_row(grp_rows[r]);
            exp_rows[bank].push_back(grp_rows[r]);
        end
        exp_kind[bank].push_back(kind);
    endtask

    task automatic start_req(input bank_idx_t bank, input tag_t kind, input row_data_t data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        wb_adr = {kind, bank};
        wb_dat = data;
    endtask

    task automatic wait_ack();
        int n;
        n = 0;
        while (!wb_ack) begin
            @(posedge CLK);
            #1;
            n++;
            if (n > TIMEOUT) fail_now("Wishbone write was never acknowledged");
        end
        @(posedge CLK);  // row enters the bank on this edge
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input bank_idx_t bank, input tag_t kind, input row_data_t data);
        start_req(bank, kind, data);
        wait_ack();
    endtask

    task automatic send_group(input bank_idx_t bank, input tag_t kind);
        queue_group(bank, kind);
        for (int r = 0; r < ROWS_PER_GROUP; r++) begin
            wb_write(bank, kind, grp_rows[r]);
        end
    endtask

    task automatic pulse_new_weight();
        new_weight = 1'b1;
        @(posedge CLK);
        #1;
        new_weight = 1'b0;
    endtask

    // nothing may leave the scheduler and no ack may appear
    task automatic quiet_cycles(input int cycles);
        repeat (cycles) begin
            @(posedge CLK);
            #1;
            check_eq("weight_en", 64'(0), 64'(weight_en));
            check_eq("input_en", 64'(0), 64'(input_en));
            check_eq("ps_en", 64'(0), 64'(ps_en));
            check_eq("wb_ack", 64'(0), 64'(wb_ack));
        end
    endtask

    task automatic expect_group(input tag_t kind);
        int   n;
        tag_t got;
        n = 0;
        while (delivered.size() == 0) begin
            @(posedge CLK);
            #1;
            n++;
            if (n > TIMEOUT) fail_now($sformatf("no %s group arrived", kind.name()));
        end
        got = delivered.pop_front();
        check_eq("group kind", 64'(kind), 64'(got));
    endtask

    task automatic wait_all_delivered();
        int n;
        int owed;
        n = 0;
        owed = 1;
        while (owed != 0) begin
            owed = 0;
            for (int b = 0; b < NUM_BANKS; b++) owed += exp_kind[b].size();
            if (owed != 0) begin
                @(posedge CLK);
                #1;
                n++;
                if (n > 4 * TIMEOUT) fail_now("written groups were never all delivered");
            end
        end
    endtask

    // ******************************
    // output monitors
    // ******************************
    // a finished group must equal the oldest owed group of some bank
    task automatic match_group(input tag_t kind);
        int   k;
        int   hit;
        logic same;
        k   = int'(kind);
        hit = -1;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (hit < 0 && exp_kind[b].size() > 0 && exp_kind[b][0] == kind) begin
                same = 1'b1;
                for (int r = 0; r < ROWS_PER_GROUP; r++) begin
                    if (exp_rows[b][r] != got_rows[k][r]) same = 1'b0;
                end
                if (same) hit = b;
            end
        end
        if (hit < 0) begin
            fail_now($sformatf("%s group starting %h is not the oldest group of any bank",
                               kind.name(), got_rows[k][0]));
        end
        void'(exp_kind[hit].pop_front());
        repeat (ROWS_PER_GROUP) void'(exp_rows[hit].pop_front());
        delivered.push_back(kind);
    endtask

    task automatic track_stream(input tag_t kind, input logic en, input row_sel_t row,
                                input row_data_t data);
        int k;
        k = int'(kind);
        if (en) begin
            check_eq($sformatf("%s row index", kind.name()), 64'(next_row[k]), 64'(row));
            got_rows[k][next_row[k]] = data;
            if (next_row[k] == ROWS_PER_GROUP - 1) begin
                next_row[k] = 0;
                match_group(kind);
            end else begin
                next_row[k]++;
            end
        end else if (next_row[k] != 0) begin
            fail_now($sformatf("%s group stopped before its last row", kind.name()));
        end
    endtask

    always @(negedge CLK) begin
        if (nRST) begin
            track_stream(TAG_WEIGHT, weight_en, wi_row, wi_data);
            track_stream(TAG_INPUT, input_en, wi_row, wi_data);
            track_stream(TAG_PSUM, ps_en, ps_row, ps_data);
            if (input_en && ps_en) overlap_count++;
        end
    end

    // ******************************
    // directed tests
    // ******************************
    task automatic test_reset_idle();
        test_name = "reset_idle";
        quiet_cycles(20);
    endtask

    task automatic test_weight_then_input();
        test_name = "weight_then_input";
        drained = 1'b1;
        send_group(2'd2, TAG_WEIGHT);
        expect_group(TAG_WEIGHT);
        send_group(2'd0, TAG_INPUT);
        expect_group(TAG_INPUT);
    endtask

    task automatic test_psum_waits();
        test_name = "psum_waits";
        pulse_new_weight();
        send_group(2'd1, TAG_PSUM);
        quiet_cycles(20);  // psums held during the load
        send_group(2'd3, TAG_WEIGHT);
        expect_group(TAG_WEIGHT);
        expect_group(TAG_PSUM);
    endtask

    task automatic test_drained_gate();
        test_name = "drained_gate";
        drained = 1'b0;
        pulse_new_weight();
        send_group(2'd0, TAG_INPUT);
        send_group(2'd1, TAG_WEIGHT);
        quiet_cycles(20);  // weights wait for the array to drain
        drained = 1'b1;
        expect_group(TAG_WEIGHT);
        expect_group(TAG_INPUT);
    endtask

    task automatic test_all_banks();
        int overlap_start;
        test_name = "all_banks";
        overlap_start = overlap_count;
        drained = 1'b0;
        pulse_new_weight();
        send_group(2'd0, TAG_INPUT);
        send_group(2'd1, TAG_PSUM);
        send_group(2'd2, TAG_WEIGHT);
        send_group(2'd2, TAG_INPUT);
        send_group(2'd3, TAG_PSUM);
        send_group(2'd0, TAG_INPUT);
        send_group(2'd1, TAG_PSUM);
        drained = 1'b1;
        expect_group(TAG_WEIGHT);
        wait_all_delivered();
        check_eq("input and psum in flight together", 64'(1),
                 64'(overlap_count > overlap_start));
        delivered.delete();
    endtask

    task automatic test_backpressure();
        test_name = "backpressure";
        drained = 1'b0;
        pulse_new_weight();
        send_group(2'd3, TAG_WEIGHT);
        for (int g = 0; g < DEPTH / ROWS_PER_GROUP; g++) send_group(2'd1, TAG_PSUM);
        queue_group(2'd1, TAG_PSUM);
        start_req(2'd1, TAG_PSUM, grp_rows[0]);
        quiet_cycles(30);  // bank 1 full, write must wait
        drained = 1'b1;
        wait_ack();
        for (int r = 1; r < ROWS_PER_GROUP; r++) wb_write(2'd1, TAG_PSUM, grp_rows[r]);
        expect_group(TAG_WEIGHT);
        for (int g = 0; g <= DEPTH / ROWS_PER_GROUP; g++) expect_group(TAG_PSUM);
    endtask

    initial begin
        CLK        = 1'b0;
        nRST       = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat     = '0;
        new_weight = 1'b0;
        drained    = 1'b0;
        lfsr       = 32'h350d8543;
        test_name  = "reset";
        overlap_count = 0;
        foreach (next_row[i]) next_row[i] = 0;
        repeat (4) @(posedge CLK);
        #1;
        nRST = 1'b1;
        test_reset_idle();
        test_weight_then_input();
        test_psum_waits();
        test_drained_gate();
        test_all_banks();
        test_backpressure();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/gemm_sched_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module gemm_sched_top #(
    parameter int DEPTH = 8  // bank FIFO depth, power of two from 4 to 16
) (
    input  logic                      CLK,
    input  logic                      nRST,

    // Wishbone classic, writes only
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [3:0]                wb_adr,
    input  gemm_sched_pkg::row_data_t wb_dat,
    output logic                      wb_ack,

    // array handshake
    input  logic                      new_weight,
    input  logic                      drained,

    // weight / input row stream
    output logic                      weight_en,
    output logic                      input_en,
    output gemm_sched_pkg::row_sel_t  wi_row,
    output gemm_sched_pkg::row_data_t wi_data,

    // partial-sum row stream
    output logic                      ps_en,
    output gemm_sched_pkg::row_sel_t  ps_row,
    output gemm_sched_pkg::row_data_t ps_data
);
    import gemm_sched_pkg::*;

    bank_mask_t push;
    bank_mask_t bank_full;
    bank_mask_t ps_pop;
    bank_mask_t wi_pop;
    tag_t       wr_tag;
    row_data_t  wr_data;
    logic       weight_pending;

    tag_t       head_tag  [NUM_BANKS];
    row_data_t  head_data [NUM_BANKS];
    level_t     level     [NUM_BANKS];

    // ******************************
    // host write port
    // ******************************
    wb_bank_writer u_writer (
        .CLK       (CLK),
        .nRST      (nRST),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat    (wb_dat),
        .wb_ack    (wb_ack),
        .bank_full (bank_full),
        .push      (push),
        .wr_tag    (wr_tag),
        .wr_data   (wr_data)
    );

    // ******************************
    // operand banks
    // ******************************
    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
        bank_fifo #(
            .DEPTH (DEPTH)
        ) u_fifo (
            .CLK       (CLK),
            .nRST      (nRST),
            .push      (push[k]),
            .wr_tag    (wr_tag),      // shared write word
            .wr_data   (wr_data),
            .pop_ps    (ps_pop[k]),
            .pop_wi    (wi_pop[k]),
            .head_tag  (head_tag[k]),
            .head_data (head_data[k]),
            .level     (level[k]),
            .full      (bank_full[k])
        );
    end

    // ******************************
    // schedulers
    // ******************************
    weight_input_scanner u_wi_scan (
        .CLK            (CLK),
        .nRST           (nRST),
        .new_weight     (new_weight),
        .drained        (drained),
        .head_tag       (head_tag),
        .head_data      (head_data),
        .level          (level),
        .pop            (wi_pop),
        .weight_pending (weight_pending),
        .weight_en      (weight_en),
        .input_en       (input_en),
        .wi_row         (wi_row),
        .wi_data        (wi_data)
    );

    psum_scanner u_ps_scan (
        .CLK            (CLK),
        .nRST           (nRST),
        .weight_pending (weight_pending),  // psums stall during a weight load
        .head_tag       (head_tag),
        .head_data      (head_data),
        .level          (level),
        .pop            (ps_pop),
        .ps_en          (ps_en),
        .ps_row         (ps_row),
        .ps_data        (ps_data)
    );

endmodule

`default_nettype wire

// ==== hdl/weight_input_scanner.sv ====
`default_nettype none
`timescale 1ns/10ps

module weight_input_scanner (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       new_weight,
    input  logic                       drained,
    input  gemm_sched_pkg::tag_t       head_tag  [gemm_sched_pkg::NUM_BANKS],
    input  gemm_sched_pkg::row_data_t  head_data [gemm_sched_pkg::NUM_BANKS],
    input  gemm_sched_pkg::level_t     level     [gemm_sched_pkg::NUM_BANKS],
    output gemm_sched_pkg::bank_mask_t pop,
    output logic                       weight_pending,
    output logic                       weight_en,
    output logic                       input_en,
    output gemm_sched_pkg::row_sel_t   wi_row,
    output gemm_sched_pkg::row_data_t  wi_data
);
    import gemm_sched_pkg::*;

    scan_state_t state;
    bank_idx_t   bank;
    row_sel_t    row;
    logic        burst_weight;  // kind of the burst in flight
    tag_t        want_tag;
    logic        group_ready;
    logic        last_row;
    logic        weight_done;
    logic        hold;

    assign want_tag    = weight_pending ? TAG_WEIGHT : TAG_INPUT;
    assign group_ready = (head_tag[bank] == want_tag) &&
                         (level[bank] >= level_t'(ROWS_PER_GROUP));
    assign last_row    = (row == row_sel_t'(ROWS_PER_GROUP - 1));
    assign weight_done = (state == SCAN_BURST) && burst_weight && last_row;
    assign hold        = weight_pending && !drained;  // array still busy with old weights

    // ******************************
    // weight load flag
    // ******************************
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            weight_pending <= 1'b1;  // nothing loaded yet
        end else if (new_weight) begin
            weight_pending <= 1'b1;  // wins over a finishing load
        end else if (weight_done) begin
            weight_pending <= 1'b0;
        end
    end

    // ******************************
    // round-robin scan
    // ******************************
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state        <= SCAN_STALL;
            bank         <= '0;
            row          <= '0;
            burst_weight <= 1'b0;
        end else begin
            case (state)
                SCAN_STALL: begin
                    if (!hold) begin
                        state <= SCAN_CHECK;
                        bank  <= '0;
                    end
                end
                SCAN_CHECK: begin
                    if (hold) begin
                        state <= SCAN_STALL;
                    end else if (group_ready) begin
                        state        <= SCAN_BURST;
                        row          <= '0;
                        burst_weight <= weight_pending;
                    end else begin
                        bank <= bank + bank_idx_t'(1);
                    end
                end
                SCAN_BURST: begin
                    // a started group always runs to its last row
                    row <= row + row_sel_t'(1);
                    if (last_row) begin
                        state <= SCAN_CHECK;
                        bank  <= bank + bank_idx_t'(1);
                    end
                end
                default: state <= SCAN_STALL;
            endcase
        end
    end

    // ******************************
    // array side
    // ******************************
    assign weight_en = (state == SCAN_BURST) && burst_weight;
    assign input_en  = (state == SCAN_BURST) && !burst_weight;
    assign wi_row    = row;
    assign wi_data   = head_data[bank];
    assign pop       = (state == SCAN_BURST) ? (bank_mask_t'(1) << bank) : '0;

    // every row of a burst carries the kind latched at its start
    a_burst_kind: assert property (@(posedge CLK) disable iff (!nRST)
        (weight_en || input_en) |->
            (head_tag[bank] == (weight_en ? TAG_WEIGHT : TAG_INPUT)));

    // the load flag only drops after the last weight row has gone out
    a_weight_in_load: assert property (@(posedge CLK) disable iff (!nRST)
        weight_en |-> weight_pending);

endmodule

`default_nettype wire

// ==== hdl/psum_scanner.sv ====
`default_nettype none
`timescale 1ns/10ps

module psum_scanner (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       weight_pending,
    input  gemm_sched_pkg::tag_t       head_tag  [gemm_sched_pkg::NUM_BANKS],
    input  gemm_sched_pkg::row_data_t  head_data [gemm_sched_pkg::NUM_BANKS],
    input  gemm_sched_pkg::level_t     level     [gemm_sched_pkg::NUM_BANKS],
    output gemm_sched_pkg::bank_mask_t pop,
    output logic                       ps_en,
    output gemm_sched_pkg::row_sel_t   ps_row,
    output gemm_sched_pkg::row_data_t  ps_data
);
    import gemm_sched_pkg::*;

    scan_state_t state;
    bank_idx_t   bank;
    row_sel_t    row;
    logic        group_ready;
    logic        last_row;

    // a whole group must sit in the bank before we start on it
    assign group_ready = (head_tag[bank] == TAG_PSUM) &&
                         (level[bank] >= level_t'(ROWS_PER_GROUP));
    assign last_row    = (row == row_sel_t'(ROWS_PER_GROUP - 1));

    // ******************************
    // round-robin scan
    // ******************************
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= SCAN_STALL;
            bank  <= '0;
            row   <= '0;
        end else if (weight_pending) begin
            state <= SCAN_STALL;  // psums wait for the new weights
            bank  <= '0;
            row   <= '0;
        end else begin
            case (state)
                SCAN_STALL: begin
                    state <= SCAN_CHECK;
                    bank  <= '0;
                end
                SCAN_CHECK: begin
                    if (group_ready) begin
                        state <= SCAN_BURST;
                        row   <= '0;
                    end else begin
                        bank <= bank + bank_idx_t'(1);  // one bank per cycle
                    end
                end
                SCAN_BURST: begin
                    row <= row + row_sel_t'(1);
                    if (last_row) begin
                        state <= SCAN_CHECK;
                        bank  <= bank + bank_idx_t'(1);
                    end
                end
                default: state <= SCAN_STALL;
            endcase
        end
    end

    // ******************************
    // array side
    // ******************************
    assign ps_en   = (state == SCAN_BURST);
    assign ps_row  = row;
    assign ps_data = head_data[bank];
    assign pop     = ps_en ? (bank_mask_t'(1) << bank) : '0;  // head leaves on the next edge

    // weight_pending comes from the other scanner
    a_no_ps_during_load: assert property (@(posedge CLK) disable iff (!nRST)
        ps_en |-> !weight_pending);

endmodule

`default_nettype wire

// ==== hdl/wb_bank_writer.sv ====
`default_nettype none
`timescale 1ns/10ps

module wb_bank_writer (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [3:0]                 wb_adr,
    input  gemm_sched_pkg::row_data_t  wb_dat,
    output logic                       wb_ack,
    input  gemm_sched_pkg::bank_mask_t bank_full,
    output gemm_sched_pkg::bank_mask_t push,
    output gemm_sched_pkg::tag_t       wr_tag,
    output gemm_sched_pkg::row_data_t  wr_data
);
    import gemm_sched_pkg::*;

    bank_idx_t bank;
    logic      req;
    logic      ack_next;

    // address map: [1:0] bank, [3:2] row kind
    assign bank   = wb_adr[1:0];
    assign wr_tag = tag_t'(wb_adr[3:2]);
    assign req    = wb_cyc && wb_stb;

    // ******************************
    // ack generation
    // ******************************
    // a write waits here while its bank is full, reads are acked and dropped
    assign ack_next = req && !wb_ack && !(wb_we && bank_full[bank]);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= ack_next;
        end
    end

    // the host still holds address and data in the ack cycle
    assign push    = (wb_ack && req && wb_we) ? (bank_mask_t'(1) << bank) : '0;
    assign wr_data = wb_dat;

    // the row is taken in the ack cycle and needs the request still up
    a_req_held: assert property (@(posedge CLK) disable iff (!nRST)
        wb_ack |-> req);

endmodule

`default_nettype wire

// ==== hdl/bank_fifo.sv ====
`default_nettype none
`timescale 1ns/10ps

module bank_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      push,
    input  gemm_sched_pkg::tag_t      wr_tag,
    input  gemm_sched_pkg::row_data_t wr_data,
    input  logic                      pop_ps,
    input  logic                      pop_wi,
    output gemm_sched_pkg::tag_t      head_tag,
    output gemm_sched_pkg::row_data_t head_data,
    output gemm_sched_pkg::level_t    level,
    output logic                      full
);
    import gemm_sched_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    tag_t             tag_mem  [DEPTH];
    row_data_t        data_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    level_t           count;
    logic             pop;

    assign pop = pop_ps || pop_wi;  // at most one scanner owns the head

    // ******************************
    // storage
    // ******************************
    always_ff @(posedge CLK) begin
        if (push) begin
            tag_mem[wr_ptr]  <= wr_tag;
            data_mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + level_t'(1);
                2'b01:   count <= count - level_t'(1);
                default: count <= count;  // idle or push and pop together
            endcase
        end
    end

    // ******************************
    // fall-through head
    // ******************************
    assign head_tag  = (count == '0) ? TAG_NONE : tag_mem[rd_ptr];  // empty bank never matches
    assign head_data = data_mem[rd_ptr];
    assign level     = count;
    assign full      = (count == level_t'(DEPTH));

    // the two scanners must never claim the same bank at once
    a_one_owner: assert property (@(posedge CLK) disable iff (!nRST)
        !(pop_ps && pop_wi));

    a_no_underflow: assert property (@(posedge CLK) disable iff (!nRST)
        pop |-> (count != '0));

    // writer holds ack while full
    a_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
        push |-> !full);

endmodule

`default_nettype wire

// ==== hdl/gemm_sched_pkg.sv ====
`default_nettype none

package gemm_sched_pkg;

    // ******************************
    // bank and group geometry
    // ******************************
    localparam int NUM_BANKS      = 4;   // fixed, bank index is 2 bits
    localparam int ROWS_PER_GROUP = 4;   // one row per array row
    localparam int DATA_W         = 64;  // operand row payload

    // ******************************
    // vector types
    // ******************************
    typedef logic [DATA_W-1:0]    row_data_t;
    typedef logic [1:0]           row_sel_t;    // array row inside a group
    typedef logic [1:0]           bank_idx_t;
    typedef logic [NUM_BANKS-1:0] bank_mask_t;  // one bit per bank
    typedef logic [4:0]           level_t;      // fill level, depth up to 16

    // row kind, carried in wb_adr[3:2] and stored next to each row
    typedef enum logic [1:0] {
        TAG_NONE   = 2'd0,
        TAG_INPUT  = 2'd1,
        TAG_WEIGHT = 2'd2,
        TAG_PSUM   = 2'd3
    } tag_t;

    // shared by both scanners
    typedef enum logic [1:0] {
        SCAN_STALL = 2'd0,
        SCAN_CHECK = 2'd1,
        SCAN_BURST = 2'd2
    } scan_state_t;

endpackage

`default_nettype wire
